// File: common/dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_W   = 24;
    localparam int WORD_W   = 16;
    localparam int TAG_W    = 16;
    localparam int IDX_W    = 6;
    localparam int OFF_W    = 2;
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 64;
    localparam int LINE_W   = WORD_W << OFF_W;   // Four words per line

    localparam logic [ADDR_W-1:0] FIRST_PAGE = 24'h000800;

    typedef logic [ADDR_W-1:0]           addr_t;
    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [1:0]                  sel_t;
    typedef logic [TAG_W-1:0]            tag_t;
    typedef logic [IDX_W-1:0]            idx_t;
    typedef logic [OFF_W-1:0]            off_t;
    typedef logic [LINE_W-1:0]           line_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // The word at offset 0 sits in the low bits of line
    typedef struct packed {
        tag_t  tag;
        line_t line;
        logic  dirty;
        logic  valid;
    } entry_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        sel_t  sel;
        logic  we;
        logic  cache_en;
    } cache_req_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
        sel_t  sel;
        logic  burst;
    } wb_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL,
        ST_EVICT,
        ST_WR_WAIT,
        ST_WR_UPDATE,
        ST_UNCACHED
    } ctrl_state_t;

endpackage

// File: dcache/dcache_ram.sv
`timescale 1ns/1ps

module dcache_ram (
    input  logic               i_clk,
    input  logic               i_rst,
    input  dcache_pkg::idx_t   i_idx,
    input  logic               i_we,
    input  dcache_pkg::entry_t i_entry,
    output dcache_pkg::entry_t o_entry
);
    dcache_pkg::entry_t mem [dcache_pkg::NUM_SETS];
    dcache_pkg::idx_t   sweep_idx;
    logic               sweeping;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sweep_idx <= '0;
            sweeping  <= 1'b1;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == dcache_pkg::idx_t'(dcache_pkg::NUM_SETS - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    // The sweep owns the write port until every set is invalid
    always_ff @(posedge i_clk) begin
        if (sweeping) begin
            mem[sweep_idx] <= '0;
        end else if (i_we) begin
            mem[i_idx] <= i_entry;
        end
        o_entry <= sweeping ? '0 : mem[i_idx];   // Old contents on a same-cycle write
    end

endmodule

// File: dcache/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup (
    input  logic               i_clk,
    input  logic               i_rst,
    input  dcache_pkg::addr_t  i_addr,
    input  dcache_pkg::entry_t i_way0,
    input  dcache_pkg::entry_t i_way1,
    input  logic               i_latch_hit,
    input  logic               i_latch_victim,
    output logic               o_hit,
    output logic               o_victim_dirty,
    output dcache_pkg::way_t   o_way,
    output dcache_pkg::entry_t o_way_entry,
    output dcache_pkg::idx_t   o_idx
);
    dcache_pkg::tag_t                  req_tag;
    logic [dcache_pkg::NUM_WAYS-1:0]   way_hit;
    dcache_pkg::way_t                  hit_way;
    dcache_pkg::way_t                  victim_way;
    dcache_pkg::way_t                  prev_way;
    dcache_pkg::way_t                  cur_way;

    assign req_tag = i_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign o_idx   = i_addr[dcache_pkg::OFF_W +: dcache_pkg::IDX_W];

    assign way_hit[0] = i_way0.valid && (i_way0.tag == req_tag);
    assign way_hit[1] = i_way1.valid && (i_way1.tag == req_tag);
    assign o_hit      = |way_hit;
    assign hit_way    = !way_hit[0];   // Only meaningful together with o_hit

    assign o_victim_dirty = i_way0.valid && i_way0.dirty && i_way1.valid && i_way1.dirty;

    always_comb begin
        if (!i_way0.valid)      victim_way = 1'b0;
        else if (!i_way1.valid) victim_way = 1'b1;
        else if (!i_way0.dirty) victim_way = 1'b0;
        else if (!i_way1.dirty) victim_way = 1'b1;
        else                    victim_way = !prev_way;   // Both dirty, alternate
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_way    <= '0;
            prev_way <= '0;
        end else if (i_latch_hit) begin
            o_way <= hit_way;
        end else if (i_latch_victim) begin
            o_way    <= victim_way;
            prev_way <= victim_way;
        end
    end

    // A read hit returns in the lookup cycle, before the way is registered
    assign cur_way     = i_latch_hit ? hit_way : o_way;
    assign o_way_entry = cur_way ? i_way1 : i_way0;

endmodule

// File: dcache/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                            i_clk,
    input  logic                            i_rst,
    input  logic                            i_req,
    input  dcache_pkg::cache_req_t          i_cmd,
    input  logic                            i_hit,
    input  logic                            i_victim_dirty,
    input  dcache_pkg::way_t                i_way,
    input  dcache_pkg::entry_t              i_way_entry,
    input  dcache_pkg::word_t               i_wb_dat,
    input  logic                            i_wb_ack,
    output dcache_pkg::ctrl_state_t         o_state,
    output logic                            o_latch_hit,
    output logic                            o_latch_victim,
    output logic                            o_ack,
    output logic                            o_exception,
    output dcache_pkg::off_t                o_beat,
    output dcache_pkg::line_t               o_line,
    output logic [dcache_pkg::NUM_WAYS-1:0] o_we,
    output dcache_pkg::wb_req_t             o_wb
);
    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_nxt;
    dcache_pkg::off_t        beat;
    logic                    illegal;
    logic                    in_lookup;
    logic                    beat_done;
    logic                    burst_end;
    logic                    fill_end;
    logic                    wr_update;

    assign illegal   = i_cmd.addr < dcache_pkg::FIRST_PAGE;
    assign in_lookup = state == dcache_pkg::ST_LOOKUP;
    assign beat_done = o_wb.cyc && o_wb.stb && i_wb_ack;
    assign burst_end = beat_done && (&beat);
    assign fill_end  = (state == dcache_pkg::ST_FILL) && burst_end;
    assign wr_update = state == dcache_pkg::ST_WR_UPDATE;

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::ST_IDLE: begin
                if (i_req && !illegal) begin
                    state_nxt = i_cmd.cache_en ? dcache_pkg::ST_LOOKUP : dcache_pkg::ST_UNCACHED;
                end
            end
            dcache_pkg::ST_LOOKUP: begin
                if (i_hit) begin
                    state_nxt = i_cmd.we ? dcache_pkg::ST_WR_UPDATE : dcache_pkg::ST_IDLE;
                end else begin
                    state_nxt = i_victim_dirty ? dcache_pkg::ST_EVICT : dcache_pkg::ST_FILL;
                end
            end
            dcache_pkg::ST_EVICT: begin
                if (burst_end) state_nxt = dcache_pkg::ST_FILL;
            end
            dcache_pkg::ST_FILL: begin
                if (burst_end) begin
                    // A write miss waits one cycle so the RAM shows the filled line
                    state_nxt = i_cmd.we ? dcache_pkg::ST_WR_WAIT : dcache_pkg::ST_IDLE;
                end
            end
            dcache_pkg::ST_WR_WAIT:   state_nxt = dcache_pkg::ST_WR_UPDATE;
            dcache_pkg::ST_WR_UPDATE: state_nxt = dcache_pkg::ST_IDLE;
            dcache_pkg::ST_UNCACHED: begin
                if (beat_done) state_nxt = dcache_pkg::ST_IDLE;
            end
            default: state_nxt = dcache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= dcache_pkg::ST_IDLE;
            beat  <= '0;
        end else begin
            state <= state_nxt;
            if (beat_done && (state != dcache_pkg::ST_UNCACHED)) begin
                beat <= beat + 1'b1;   // Wraps to zero after the fourth beat
            end
        end
    end

    // On the last beat the merge stage reads the word from the bus instead
    always_ff @(posedge i_clk) begin
        if ((state == dcache_pkg::ST_FILL) && beat_done) begin
            o_line[beat * dcache_pkg::WORD_W +: dcache_pkg::WORD_W] <= i_wb_dat;
        end
    end

    always_comb begin
        o_we        = '0;
        o_we[i_way] = fill_end || wr_update;
    end

    always_comb begin
        o_wb.cyc = (state == dcache_pkg::ST_EVICT) || (state == dcache_pkg::ST_FILL) ||
                   (state == dcache_pkg::ST_UNCACHED);
        o_wb.stb = o_wb.cyc;
        o_wb.we  = (state == dcache_pkg::ST_EVICT) ||
                   ((state == dcache_pkg::ST_UNCACHED) && i_cmd.we);
        if (state == dcache_pkg::ST_UNCACHED) begin
            o_wb.adr = i_cmd.addr;
        end else if (state == dcache_pkg::ST_EVICT) begin
            o_wb.adr = {i_way_entry.tag, i_cmd.addr[dcache_pkg::OFF_W +: dcache_pkg::IDX_W], beat};
        end else begin
            o_wb.adr = {i_cmd.addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFF_W], beat};
        end
        o_wb.dat   = '0;   // Write data is supplied by the merge stage
        o_wb.sel   = i_cmd.cache_en ? 2'b11 : i_cmd.sel;
        o_wb.burst = i_cmd.cache_en;
    end

    assign o_ack = (in_lookup && i_hit && !i_cmd.we) || (fill_end && !i_cmd.we) || wr_update ||
                   ((state == dcache_pkg::ST_UNCACHED) && beat_done);

    assign o_exception    = (state == dcache_pkg::ST_IDLE) && i_req && illegal;
    assign o_latch_hit    = in_lookup && i_hit;
    assign o_latch_victim = in_lookup && !i_hit;
    assign o_state        = state;
    assign o_beat         = beat;

endmodule

// File: dcache/dcache_merge.sv
`timescale 1ns/1ps

module dcache_merge (
    input  dcache_pkg::cache_req_t  i_cmd,
    input  dcache_pkg::ctrl_state_t i_state,
    input  dcache_pkg::entry_t      i_hit_entry,
    input  dcache_pkg::line_t       i_line,
    input  dcache_pkg::word_t       i_wb_dat,
    input  dcache_pkg::off_t        i_beat,
    output dcache_pkg::word_t       o_rdata,
    output dcache_pkg::word_t       o_wb_dat,
    output dcache_pkg::entry_t      o_entry
);
    dcache_pkg::off_t   req_off;
    dcache_pkg::line_t  fill_line;
    dcache_pkg::line_t  upd_line;
    dcache_pkg::word_t  evict_word;
    logic               in_fill;

    assign req_off = i_cmd.addr[dcache_pkg::OFF_W-1:0];
    assign in_fill = i_state == dcache_pkg::ST_FILL;

    // On the last fill beat the top word is still on the bus
    assign fill_line = {i_wb_dat, i_line[3*dcache_pkg::WORD_W-1:0]};

    always_comb begin
        if (!i_cmd.cache_en) begin
            o_rdata = i_wb_dat;
        end else if (in_fill) begin
            o_rdata = fill_line[req_off * dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
        end else begin
            o_rdata = i_hit_entry.line[req_off * dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
        end
    end

    assign evict_word = i_hit_entry.line[i_beat * dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
    assign o_wb_dat   = i_cmd.cache_en ? evict_word : i_cmd.wdata;

    always_comb begin
        upd_line = i_hit_entry.line;
        if (i_cmd.sel[0]) upd_line[req_off * dcache_pkg::WORD_W +: 8]     = i_cmd.wdata[7:0];
        if (i_cmd.sel[1]) upd_line[req_off * dcache_pkg::WORD_W + 8 +: 8] = i_cmd.wdata[15:8];
    end

    always_comb begin
        if (in_fill) begin
            o_entry.tag   = i_cmd.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
            o_entry.line  = fill_line;
            o_entry.dirty = 1'b0;
        end else begin
            o_entry.tag   = i_hit_entry.tag;
            o_entry.line  = upd_line;
            o_entry.dirty = 1'b1;
        end
        o_entry.valid = 1'b1;
    end

endmodule

// File: dcache/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_req,
    input  dcache_pkg::cache_req_t i_cmd,
    output logic                   o_ack,
    output dcache_pkg::word_t      o_rdata,
    output logic                   o_exception,
    output dcache_pkg::wb_req_t    o_wb,
    input  dcache_pkg::word_t      i_wb_dat,
    input  logic                   i_wb_ack
);
    dcache_pkg::entry_t              way0_entry;
    dcache_pkg::entry_t              way1_entry;
    dcache_pkg::entry_t              way_entry;
    dcache_pkg::entry_t              store_entry;
    dcache_pkg::idx_t                idx;
    dcache_pkg::way_t                way;
    dcache_pkg::ctrl_state_t         state;
    dcache_pkg::off_t                beat;
    dcache_pkg::line_t               line;
    dcache_pkg::wb_req_t             wb_ctrl;
    dcache_pkg::word_t               wb_wdata;
    logic [dcache_pkg::NUM_WAYS-1:0] way_we;
    logic                            hit;
    logic                            victim_dirty;
    logic                            latch_hit;
    logic                            latch_victim;

    dcache_ram u_way0 (.i_clk, .i_rst, .i_idx(idx), .i_we(way_we[0]),
                       .i_entry(store_entry), .o_entry(way0_entry));
    dcache_ram u_way1 (.i_clk, .i_rst, .i_idx(idx), .i_we(way_we[1]),
                       .i_entry(store_entry), .o_entry(way1_entry));

    dcache_lookup u_lookup (.i_clk, .i_rst, .i_addr(i_cmd.addr), .i_way0(way0_entry),
                            .i_way1(way1_entry), .i_latch_hit(latch_hit),
                            .i_latch_victim(latch_victim), .o_hit(hit),
                            .o_victim_dirty(victim_dirty), .o_way(way),
                            .o_way_entry(way_entry), .o_idx(idx));

    dcache_ctrl u_ctrl (.i_clk, .i_rst, .i_req, .i_cmd, .i_hit(hit),
                        .i_victim_dirty(victim_dirty), .i_way(way), .i_way_entry(way_entry),
                        .i_wb_dat, .i_wb_ack, .o_state(state), .o_latch_hit(latch_hit),
                        .o_latch_victim(latch_victim), .o_ack, .o_exception, .o_beat(beat),
                        .o_line(line), .o_we(way_we), .o_wb(wb_ctrl));

    dcache_merge u_merge (.i_cmd, .i_state(state), .i_hit_entry(way_entry), .i_line(line),
                          .i_wb_dat, .i_beat(beat), .o_rdata, .o_wb_dat(wb_wdata),
                          .o_entry(store_entry));

    always_comb begin
        o_wb     = wb_ctrl;
        o_wb.dat = wb_wdata;   // Victim word or uncached write data
    end

endmodule

// File: sim/dcache_props.sv
`timescale 1ns/1ps

module dcache_props (
    input logic                i_clk,
    input logic                i_rst,
    input logic                i_req,
    input logic                o_ack,
    input logic                o_exception,
    input dcache_pkg::wb_req_t o_wb,
    input logic                i_wb_ack
);
    logic seen_req;

    always_ff @(posedge i_clk) begin
        if (i_rst) seen_req <= 1'b0;
        else if (i_req) seen_req <= 1'b1;
    end

    a_stb_cyc: assert property (@(posedge i_clk) disable iff (i_rst) o_wb.stb |-> o_wb.cyc)
        else $error("stb without cyc");

    a_ack_exc: assert property (@(posedge i_clk) disable iff (i_rst) !(o_ack && o_exception))
        else $error("ack and exception together");

    // A stalled beat keeps its address and data
    a_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        o_wb.stb && !i_wb_ack |=> $stable(o_wb.adr) && $stable(o_wb.dat))
        else $error("bus address or data changed during a stall");

    a_idle_bus: assert property (@(posedge i_clk) disable iff (i_rst) !seen_req |-> !o_wb.cyc)
        else $error("bus cycle before the first request");

endmodule

// File: sim/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    localparam int NUM_OPS = 2000;
    localparam int LIMIT   = (NUM_OPS + 16) * 40 + 200;   // Cycles for all operations and reset

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_req;
    dcache_pkg::cache_req_t i_cmd;
    logic                   o_ack;
    dcache_pkg::word_t      o_rdata;
    logic                   o_exception;
    dcache_pkg::wb_req_t    o_wb;
    dcache_pkg::word_t      wb_dat;
    logic                   wb_ack;

    dcache_pkg::word_t      slave_mem [8192];
    dcache_pkg::word_t      model_mem [8192];
    dcache_pkg::cache_req_t cur_cmd;
    logic                   cur_illegal;
    logic [31:0]            op_lfsr;
    logic [31:0]            slave_lfsr;
    logic [31:0]            delay;
    int                     beat_cnt;
    int                     cycles;

    dcache_top i_dut (.i_clk, .i_rst, .i_req, .i_cmd, .o_ack, .o_rdata, .o_exception, .o_wb,
                      .i_wb_dat(wb_dat), .i_wb_ack(wb_ack));

    bind dcache_top dcache_props u_props (.i_clk(i_clk), .i_rst(i_rst), .i_req(i_req),
                                          .o_ack(o_ack), .o_exception(o_exception),
                                          .o_wb(o_wb), .i_wb_ack(i_wb_ack));

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    task automatic fail_now();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input dcache_pkg::word_t act, input dcache_pkg::word_t exp,
                              input string what);
        if (act !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, what, act, exp);
            fail_now();
        end
    endtask

    task automatic check_wb(input dcache_pkg::wb_req_t act, input dcache_pkg::wb_req_t exp);
        if (act !== exp) begin
            $display("Error at %0t: bus beat got %p expected %p", $time, act, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, what, act, exp);
            fail_now();
        end
    endtask

    task automatic run_op(input dcache_pkg::cache_req_t cmd);
        dcache_pkg::word_t rdata;
        @(negedge i_clk);
        i_cmd       = cmd;
        i_req       = 1'b1;
        cur_cmd     = cmd;
        cur_illegal = cmd.addr < 24'h000800;
        beat_cnt    = 0;
        if (cur_illegal) begin
            @(posedge i_clk);
            check_flag(o_exception, 1'b1, "exception");
            check_flag(o_ack, 1'b0, "ack for an illegal address");
        end else begin
            do begin
                @(posedge i_clk);
                check_flag(o_exception, 1'b0, "exception for a legal address");
            end while (!o_ack);
            rdata = o_rdata;
            if (!cmd.we) check_word(rdata, model_mem[cmd.addr[12:0]], "read data");
            if (cmd.we && cmd.sel[0]) model_mem[cmd.addr[12:0]][7:0]  = cmd.wdata[7:0];
            if (cmd.we && cmd.sel[1]) model_mem[cmd.addr[12:0]][15:8] = cmd.wdata[15:8];
        end
        @(negedge i_clk);
        i_req = 1'b0;
        if (!cur_illegal && !cmd.cache_en && beat_cnt != 1) begin
            $display("Uncached access made %0d bus beats instead of one", beat_cnt);
            fail_now();
        end
    endtask

    // Every completed beat is checked against the request and the model
    always @(posedge i_clk) begin
        dcache_pkg::wb_req_t act;
        dcache_pkg::wb_req_t exp;
        if (!i_rst && o_wb.cyc && cur_illegal) begin
            $display("Bus cycle started for an illegal address");
            fail_now();
        end
        if (!i_rst && o_wb.cyc && o_wb.stb && wb_ack) begin
            act = o_wb;
            exp = '{cyc: 1'b1, stb: 1'b1, we: cur_cmd.we, adr: cur_cmd.addr,
                    dat: cur_cmd.wdata, sel: cur_cmd.sel, burst: 1'b0};
            if (cur_cmd.cache_en) begin
                exp.we    = o_wb.we;
                exp.sel   = 2'b11;
                exp.burst = 1'b1;
                if (o_wb.we) begin   // Writeback must carry the architectural value
                    exp.adr = {o_wb.adr[23:8], cur_cmd.addr[7:2], 2'(beat_cnt)};
                    exp.dat = model_mem[o_wb.adr[12:0]];
                end else begin
                    exp.adr = {cur_cmd.addr[23:2], 2'(beat_cnt)};
                end
            end
            if (!exp.we) begin   // Read beats carry no write data
                act.dat = '0;
                exp.dat = '0;
            end
            check_wb(act, exp);
            beat_cnt++;
        end
    end

    // Bus slave with 0 to 3 wait cycles per beat
    always @(negedge i_clk) begin
        wb_ack = 1'b0;
        if (o_wb.cyc && o_wb.stb) begin
            if (delay == 0) begin
                wb_ack = 1'b1;
                wb_dat = slave_mem[o_wb.adr[12:0]];
                if (o_wb.we && o_wb.sel[0]) slave_mem[o_wb.adr[12:0]][7:0]  = o_wb.dat[7:0];
                if (o_wb.we && o_wb.sel[1]) slave_mem[o_wb.adr[12:0]][15:8] = o_wb.dat[15:8];
                draw(slave_lfsr, 2, delay);
            end else begin
                delay = delay - 1;
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles without finishing the test", cycles);
            fail_now();
        end
    end

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    initial begin
        logic [31:0] kind;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;
        i_rst       = 1'b1;
        i_req       = 1'b0;
        i_cmd       = '0;
        cur_cmd     = '0;
        cur_illegal = 1'b0;
        wb_ack      = 1'b0;
        wb_dat      = '0;
        cycles      = 0;
        op_lfsr     = 32'hdfc7_43b6;
        slave_lfsr  = 32'hdfc7_43b6;
        draw(slave_lfsr, 2, delay);
        for (int i = 0; i < 8192; i++) begin
            slave_mem[i] = 16'(i) ^ {i[7:0], 8'(i >> 5)} ^ 16'h5a3c;
            model_mem[i] = slave_mem[i];
        end
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        repeat (70) @(negedge i_clk);   // RAM reset sweep
        // Dirty one line, push it out through its set, then read it back
        for (int t = 0; t < 4; t++) begin
            run_op('{addr: 24'h000804 + 24'(t << 8), wdata: 16'h1234 + 16'(t),
                     sel: 2'(t % 3 + 1), we: 1'b1, cache_en: 1'b1});
        end
        run_op('{addr: 24'h000804, wdata: '0, sel: 2'b11, we: 1'b0, cache_en: 1'b1});
        for (int n = 0; n < NUM_OPS; n++) begin
            draw(op_lfsr, 4, kind);
            draw(op_lfsr, 10, a);
            draw(op_lfsr, 16, d);
            draw(op_lfsr, 2, s);
            if (s == 0) s = 3;
            if (kind < 12) begin
                run_op('{addr: 24'h000800 + a[9:0], wdata: d[15:0], sel: s[1:0],
                         we: kind[0], cache_en: 1'b1});
            end else if (kind < 15) begin
                run_op('{addr: 24'h001000 + a[7:0], wdata: d[15:0], sel: s[1:0],
                         we: kind[0], cache_en: 1'b0});
            end else begin
                run_op('{addr: 24'(a[9:0]), wdata: d[15:0], sel: s[1:0],
                         we: 1'b0, cache_en: 1'b1});
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: compile.f
common/dcache_pkg.sv
dcache/dcache_ram.sv
dcache/dcache_lookup.sv
dcache/dcache_ctrl.sv
dcache/dcache_merge.sv
dcache/dcache_top.sv
sim/dcache_props.sv
sim/tb_dcache.sv
